/* files.f */
rtl/hazard_pkg.sv
rtl/hazard_unit.sv
rtl/branch_predictor.sv
rtl/intercept_ctrl.sv
rtl/pipe_ctrl_regs.sv
rtl/pipe_ctrl_top.sv
testbench/pipe_ctrl_props.sv
testbench/pipe_ctrl_tb.sv

/* testbench/pipe_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_tb import hazard_pkg::*; ();

    localparam int HALF     = 50;
    localparam int IDX_W    = 4;
    localparam int DEPTH    = 1 << IDX_W;
    localparam int TIMEOUT  = 20;
    localparam int N_RANDOM = 300;
    // Directed branch PCs, table slots 1 and 2
    localparam logic [PC_W-1:0] PC_A = 16'h0002;
    localparam logic [PC_W-1:0] PC_B = 16'h0004;

    logic clk = 1'b0;
    logic rst_i;
    logic memtoreg_i;
    logic memread_i;
    logic [REG_ID_W-1:0] regdst_i;
    logic memtoreg_mem_i;
    logic memread_mem_i;
    logic [REG_ID_W-1:0] regdst_mem_i;
    logic [REG_ID_W-1:0] regsrc1_i;
    logic [REG_ID_W-1:0] regsrc2_i;
    logic [REG_ID_W-1:0] regsrc_sw_i;
    logic [REG_ID_W-1:0] regsrc1_id_i;
    logic isjump_i;
    logic isbranch_i;
    logic ifbranch_i;
    logic [PC_W-1:0] branch_pc_i;
    logic ram2_conflict_i;
    logic interception_i;
    logic [PC_W-1:0] epc_i;
    logic stall_pc_o;
    logic stall_if_o;
    logic flush_if_o;
    logic flush_id_o;
    logic flush_ex_o;
    logic isintzero_o;
    logic jr_o;
    logic prewrong_o;
    logic precorrc_o;
    logic prediction_o;
    logic psel_i;
    logic penable_i;
    logic pwrite_i;
    logic [APB_AW-1:0] paddr_i;
    logic [APB_DW-1:0] pwdata_i;
    logic [APB_DW-1:0] prdata_o;
    logic pready_o;
    logic pslverr_o;

    // Reference copy of the counter table, CTRL and event counts
    logic [1:0]        model_tbl [DEPTH];
    logic [CTRL_W-1:0] ctrl_model;
    logic [CNT_W-1:0]  stall_cnt;
    logic [CNT_W-1:0]  misp_cnt;
    integer            seed;

    pipe_ctrl_top #(.IDX_W(IDX_W)) dut (.CLK(clk), .*);

    always #HALF clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Error handling
    ////////////////////////////////////////////////////////////

    task automatic stop_on_error();
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s is 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    // Bound property failures
    always @(negedge clk) begin
        if (dut.u_props.assert_failed) begin
            $display("A bound assertion failed before %0t", $time);
            stop_on_error();
        end
    end

    ////////////////////////////////////////////////////////////
    // Pipeline stimulus
    ////////////////////////////////////////////////////////////

    task automatic drive_idle();
        memtoreg_i      = 1'b0;
        memread_i       = 1'b0;
        regdst_i        = '0;
        regsrc1_i       = '0;
        regsrc2_i       = '0;
        regsrc_sw_i     = '0;
        memtoreg_mem_i  = 1'b0;
        memread_mem_i   = 1'b0;
        regdst_mem_i    = '0;
        regsrc1_id_i    = '0;
        isjump_i        = 1'b0;
        isbranch_i      = 1'b0;
        ifbranch_i      = 1'b0;
        // Slot 0 is never trained, so idle never predicts taken
        branch_pc_i     = '0;
        ram2_conflict_i = 1'b0;
        interception_i  = 1'b0;
        epc_i           = '0;
    endtask

    // Mid-cycle check, then model update for the coming rising edge
    task automatic judge_cycle();
        logic             exp_stall;
        logic             exp_pred;
        logic             wrong;
        logic [IDX_W-1:0] idx;
        #(HALF / 2);
        idx = branch_pc_i[IDX_W:1];
        exp_stall = (memtoreg_i && memread_i &&
                     (regsrc1_i == regdst_i || regsrc2_i == regdst_i ||
                      regsrc_sw_i == regdst_i)) ||
                    ((isjump_i || isbranch_i) && memtoreg_mem_i && memread_mem_i &&
                     regsrc1_id_i == regdst_mem_i) ||
                    ram2_conflict_i;
        exp_pred = ctrl_model[CTRL_PRED_EN_BIT] && model_tbl[idx][1];
        wrong    = isbranch_i ? (exp_pred != ifbranch_i) : exp_pred;
        check_value("stall_pc_o", stall_pc_o, exp_stall);
        check_value("prediction_o", prediction_o, exp_pred);
        if (exp_stall && stall_cnt != '1) begin
            stall_cnt++;
        end
        if (wrong && !exp_stall && misp_cnt != '1) begin
            misp_cnt++;
        end
        // Resolved branch trains its slot
        if (isbranch_i && !exp_stall) begin
            if (ifbranch_i && model_tbl[idx] != 2'd3) begin
                model_tbl[idx]++;
            end else if (!ifbranch_i && model_tbl[idx] != 2'd0) begin
                model_tbl[idx]--;
            end
        end
    endtask

    task automatic drive_pipe(input logic br, input logic taken, input logic [PC_W-1:0] pc);
        @(negedge clk);
        drive_idle();
        isbranch_i  = br;
        ifbranch_i  = taken;
        branch_pc_i = pc;
        judge_cycle();
    endtask

    // Two-bit ids so matches are frequent
    task automatic drive_random();
        logic [31:0] r;
        @(negedge clk);
        r = $random(seed);
        memtoreg_i      = r[0];
        memread_i       = r[1];
        regdst_i        = {2'b00, r[3:2]};
        regsrc1_i       = {2'b00, r[5:4]};
        regsrc2_i       = {2'b00, r[7:6]};
        regsrc_sw_i     = {2'b00, r[9:8]};
        memtoreg_mem_i  = r[10];
        memread_mem_i   = r[11];
        regdst_mem_i    = {2'b00, r[13:12]};
        regsrc1_id_i    = {2'b00, r[15:14]};
        isjump_i        = (r[18:16] == 3'd0);
        isbranch_i      = !isjump_i && r[19];
        ifbranch_i      = r[20];
        ram2_conflict_i = (r[23:21] == 3'd0);
        // Slots 8 to 15 only
        branch_pc_i     = {r[31:27], 6'd0, 1'b1, r[26:24], 1'b0};
        judge_cycle();
    endtask

    // Request rises in cycle 0, pulse expected in cycle 1 only
    task automatic request_int(input logic [PC_W-1:0] epc, input int hold, input logic en);
        for (int i = 0; i < hold + 2; i++) begin
            @(negedge clk);
            interception_i = (i < hold);
            epc_i          = epc + PC_W'(i);
            #(HALF / 2);
            check_value("isintzero_o", isintzero_o, en && i == 1);
            check_value("flush_ex_o", flush_ex_o, en && i == 1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // APB access
    ////////////////////////////////////////////////////////////

    function automatic logic is_unmapped(input logic [APB_AW-1:0] addr);
        return !(addr inside {ADDR_CTRL, ADDR_EPC, ADDR_STALL_CNT, ADDR_MISPRED_CNT});
    endfunction

    task automatic apb_xfer(input logic write, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata,
                            output logic [APB_DW-1:0] rdata, output logic err);
        int n;
        @(negedge clk);
        drive_idle();
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk);
        penable_i = 1'b1;
        n = 0;
        #(HALF / 2);
        while (!pready_o) begin
            if (n == TIMEOUT) begin
                $display("APB access to 0x%0h timed out waiting for pready", addr);
                stop_on_error();
            end
            n++;
            @(negedge clk);
            #(HALF / 2);
        end
        // Sampled before the completing rising edge
        rdata = prdata_o;
        err   = pslverr_o;
        @(negedge clk);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
        logic [APB_DW-1:0] rdata;
        logic              err;
        apb_xfer(1'b1, addr, data, rdata, err);
        check_value("pslverr_o", err, is_unmapped(addr));
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] exp);
        logic [APB_DW-1:0] rdata;
        logic              err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check_value("pslverr_o", err, is_unmapped(addr));
        check_value("prdata_o", rdata, exp);
    endtask

    task automatic set_ctrl(input logic [CTRL_W-1:0] value);
        apb_write(ADDR_CTRL, APB_DW'(value));
        ctrl_model = value;
        apb_read(ADDR_CTRL, APB_DW'(value));
    endtask

    // Compare both counters, then clear them
    task automatic check_and_clear_counts();
        apb_read(ADDR_STALL_CNT, APB_DW'(stall_cnt));
        apb_read(ADDR_MISPRED_CNT, APB_DW'(misp_cnt));
        apb_write(ADDR_STALL_CNT, '0);
        apb_write(ADDR_MISPRED_CNT, '0);
        stall_cnt = '0;
        misp_cnt  = '0;
        apb_read(ADDR_STALL_CNT, '0);
        apb_read(ADDR_MISPRED_CNT, '0);
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////

    initial begin
        seed      = 32'h63e53531;
        rst_i     = 1'b1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        drive_idle();
        ctrl_model = '0;
        stall_cnt  = '0;
        misp_cnt   = '0;
        for (int i = 0; i < DEPTH; i++) begin
            model_tbl[i] = 2'b01;
        end
        repeat (3) @(negedge clk);
        rst_i = 1'b0;

        // Reset values
        apb_read(ADDR_CTRL, '0);
        apb_read(ADDR_EPC, '0);
        apb_read(ADDR_STALL_CNT, '0);
        apb_read(ADDR_MISPRED_CNT, '0);

        // Training with prediction off, output stays low
        drive_pipe(1'b1, 1'b1, PC_A);
        drive_pipe(1'b1, 1'b1, PC_A);
        drive_pipe(1'b0, 1'b0, PC_A);

        // Prediction on, slot A already strong taken
        set_ctrl(2'b10);
        drive_pipe(1'b0, 1'b0, PC_A);
        drive_pipe(1'b1, 1'b1, PC_B);
        drive_pipe(1'b1, 1'b1, PC_B);
        drive_pipe(1'b1, 1'b0, PC_B);
        drive_pipe(1'b1, 1'b0, PC_B);
        drive_pipe(1'b0, 1'b0, PC_B);

        // Random hazards and branches
        repeat (N_RANDOM) drive_random();
        check_and_clear_counts();
        set_ctrl(2'b00);
        repeat (N_RANDOM / 2) drive_random();
        check_and_clear_counts();

        // Requests ignored with int_en clear
        set_ctrl(2'b10);
        request_int(16'h1234, 4, 1'b0);
        apb_read(ADDR_EPC, '0);

        // One pulse, EPC from the sampling edge
        set_ctrl(2'b11);
        request_int(16'h4a5c, 4, 1'b1);
        apb_read(ADDR_EPC, 32'h4a5c);
        apb_write(ADDR_EPC, 32'hffff);
        apb_read(ADDR_EPC, 32'h4a5c);

        // Unmapped addresses
        apb_write(4'h2, 32'h0);
        apb_read(4'h6, '0);
        apb_read(ADDR_CTRL, 32'h3);

        repeat (2) @(negedge clk);
        if (dut.u_props.assert_failed) begin
            $display("A bound assertion failed at the end of the run");
            stop_on_error();
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* testbench/pipe_ctrl_props.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_props (
    input wire CLK,
    input wire rst_i,
    input wire isjump_i,
    input wire isbranch_i,
    input wire ifbranch_i,
    input wire interception_i,
    input wire int_en_i,
    input wire pred_en_i,
    input wire prediction_i,
    input wire stall_pc_i,
    input wire stall_if_i,
    input wire flush_if_i,
    input wire flush_id_i,
    input wire flush_ex_i,
    input wire isintzero_i,
    input wire jr_i,
    input wire prewrong_i,
    input wire precorrc_i
);

    // Raised by any failing property
    bit assert_failed = 1'b0;

    logic wrong;
    logic right;

    // Judgement before the stall mask
    assign wrong = isbranch_i ? (prediction_i != ifbranch_i) : prediction_i;
    assign right = isbranch_i && (prediction_i == ifbranch_i);

    ////////////////////////////////////////////////////////////
    // Hazard and prediction
    ////////////////////////////////////////////////////////////

    // PC, IF and ID share one stall
    a_stall_outs: assert property (@(posedge CLK) disable iff (rst_i)
        (stall_if_i == stall_pc_i) && (flush_id_i == (stall_pc_i || isintzero_i)))
    else begin
        assert_failed = 1'b1;
        $error("stall_if or flush_id does not follow the stall");
    end

    // Judgement held off while frozen
    a_judge: assert property (@(posedge CLK) disable iff (rst_i)
        (prewrong_i == (wrong && !stall_pc_i)) && (precorrc_i == (right && !stall_pc_i)))
    else begin
        assert_failed = 1'b1;
        $error("prewrong or precorrc breaks the judgement rule");
    end

    a_jump: assert property (@(posedge CLK) disable iff (rst_i)
        (jr_i == isjump_i) && (flush_if_i == (wrong || isjump_i)))
    else begin
        assert_failed = 1'b1;
        $error("jr or flush_if does not follow the jump and judgement");
    end

    a_pred_off: assert property (@(posedge CLK) disable iff (rst_i)
        !pred_en_i |-> !prediction_i)
    else begin
        assert_failed = 1'b1;
        $error("prediction raised while prediction is disabled");
    end

    ////////////////////////////////////////////////////////////
    // Interception
    ////////////////////////////////////////////////////////////

    // Pulse only after an enabled request
    a_int_cause: assert property (@(posedge CLK) disable iff (rst_i)
        isintzero_i |-> $past(int_en_i && interception_i))
    else begin
        assert_failed = 1'b1;
        $error("intercept pulse without an enabled request");
    end

    // Fresh request while enabled, taken next cycle
    a_int_take: assert property (@(posedge CLK) disable iff (rst_i)
        (int_en_i && interception_i && !$past(interception_i)) |=> isintzero_i)
    else begin
        assert_failed = 1'b1;
        $error("enabled request was not taken");
    end

    a_int_pulse: assert property (@(posedge CLK) disable iff (rst_i)
        isintzero_i |=> !isintzero_i)
    else begin
        assert_failed = 1'b1;
        $error("intercept pulse longer than one cycle");
    end

    a_flush_ex: assert property (@(posedge CLK) disable iff (rst_i)
        flush_ex_i == isintzero_i)
    else begin
        assert_failed = 1'b1;
        $error("flush_ex does not follow the intercept pulse");
    end

endmodule

// Attached to every pipeline control top
bind pipe_ctrl_top pipe_ctrl_props u_props (
    .CLK            (CLK),
    .rst_i          (rst_i),
    .isjump_i       (isjump_i),
    .isbranch_i     (isbranch_i),
    .ifbranch_i     (ifbranch_i),
    .interception_i (interception_i),
    .int_en_i       (int_en),
    .pred_en_i      (pred_en),
    .prediction_i   (prediction_o),
    .stall_pc_i     (stall_pc_o),
    .stall_if_i     (stall_if_o),
    .flush_if_i     (flush_if_o),
    .flush_id_i     (flush_id_o),
    .flush_ex_i     (flush_ex_o),
    .isintzero_i    (isintzero_o),
    .jr_i           (jr_o),
    .prewrong_i     (prewrong_o),
    .precorrc_i     (precorrc_o)
);

`default_nettype wire

/* rtl/pipe_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_top import hazard_pkg::*; #(
    parameter int IDX_W = 4
) (
    input  wire                CLK,
    input  wire                rst_i,
    // EX and MEM stage loads
    input  wire                memtoreg_i,
    input  wire                memread_i,
    input  wire [REG_ID_W-1:0] regdst_i,
    input  wire                memtoreg_mem_i,
    input  wire                memread_mem_i,
    input  wire [REG_ID_W-1:0] regdst_mem_i,
    // ID stage sources, jump and branch
    input  wire [REG_ID_W-1:0] regsrc1_i,
    input  wire [REG_ID_W-1:0] regsrc2_i,
    input  wire [REG_ID_W-1:0] regsrc_sw_i,
    input  wire [REG_ID_W-1:0] regsrc1_id_i,
    input  wire                isjump_i,
    input  wire                isbranch_i,
    input  wire                ifbranch_i,
    input  wire [PC_W-1:0]     branch_pc_i,
    input  wire                ram2_conflict_i,
    input  wire                interception_i,
    input  wire [PC_W-1:0]     epc_i,
    // Pipeline controls
    output logic               stall_pc_o,
    output logic               stall_if_o,
    output logic               flush_if_o,
    output logic               flush_id_o,
    output logic               flush_ex_o,
    output logic               isintzero_o,
    output logic               jr_o,
    output logic               prewrong_o,
    output logic               precorrc_o,
    output logic               prediction_o,
    // APB slave
    input  wire                psel_i,
    input  wire                penable_i,
    input  wire                pwrite_i,
    input  wire [APB_AW-1:0]   paddr_i,
    input  wire [APB_DW-1:0]   pwdata_i,
    output logic [APB_DW-1:0]  prdata_o,
    output logic               pready_o,
    output logic               pslverr_o
);

    logic            stall;
    logic            prewrong;
    logic            branch_done;
    logic            intercepted;
    logic            int_en;
    logic            pred_en;
    logic [PC_W-1:0] saved_epc;

    // PC and IF share one freeze
    assign stall_pc_o  = stall;
    assign stall_if_o  = stall;
    assign isintzero_o = intercepted;
    assign prewrong_o  = prewrong;

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////

    hazard_unit u_hazard (
        .memtoreg_i      (memtoreg_i),
        .memread_i       (memread_i),
        .regdst_i        (regdst_i),
        .regsrc1_i       (regsrc1_i),
        .regsrc2_i       (regsrc2_i),
        .regsrc_sw_i     (regsrc_sw_i),
        .memtoreg_mem_i  (memtoreg_mem_i),
        .memread_mem_i   (memread_mem_i),
        .regdst_mem_i    (regdst_mem_i),
        .regsrc1_id_i    (regsrc1_id_i),
        .isjump_i        (isjump_i),
        .isbranch_i      (isbranch_i),
        .ifbranch_i      (ifbranch_i),
        .prediction_i    (prediction_o),
        .ram2_conflict_i (ram2_conflict_i),
        .intercepted_i   (intercepted),
        .stall_o         (stall),
        .prewrong_o      (prewrong),
        .precorrc_o      (precorrc_o),
        .jr_o            (jr_o),
        .branch_done_o   (branch_done),
        .flush_if_o      (flush_if_o),
        .flush_id_o      (flush_id_o),
        .flush_ex_o      (flush_ex_o)
    );

    // Table size set here
    branch_predictor #(
        .IDX_W (IDX_W)
    ) u_bp (
        .CLK           (CLK),
        .rst_i         (rst_i),
        .pred_en_i     (pred_en),
        .branch_pc_i   (branch_pc_i),
        .branch_done_i (branch_done),
        .ifbranch_i    (ifbranch_i),
        .prediction_o  (prediction_o)
    );

    intercept_ctrl u_int (
        .CLK            (CLK),
        .rst_i          (rst_i),
        .int_en_i       (int_en),
        .interception_i (interception_i),
        .epc_i          (epc_i),
        .intercepted_o  (intercepted),
        .saved_epc_o    (saved_epc)
    );

    pipe_ctrl_regs u_regs (
        .CLK         (CLK),
        .rst_i       (rst_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .saved_epc_i (saved_epc),
        .stall_i     (stall),
        .prewrong_i  (prewrong),
        .int_en_o    (int_en),
        .pred_en_o   (pred_en)
    );

endmodule

`default_nettype wire

/* rtl/pipe_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_regs import hazard_pkg::*; (
    input  wire               CLK,
    input  wire               rst_i,
    // APB slave
    input  wire               psel_i,
    input  wire               penable_i,
    input  wire               pwrite_i,
    input  wire  [APB_AW-1:0] paddr_i,
    input  wire  [APB_DW-1:0] pwdata_i,
    output logic [APB_DW-1:0] prdata_o,
    output logic              pready_o,
    output logic              pslverr_o,
    // Status from the pipeline
    input  wire  [PC_W-1:0]   saved_epc_i,
    input  wire               stall_i,
    input  wire               prewrong_i,
    // Control to the pipeline
    output logic              int_en_o,
    output logic              pred_en_o
);

    logic              access;
    logic              wr_en;
    logic              hit_ctrl;
    logic              hit_epc;
    logic              hit_stall;
    logic              hit_misp;
    logic              addr_hit;
    logic [CTRL_W-1:0] ctrl_q;
    logic [CNT_W-1:0]  stall_cnt_q;
    logic [CNT_W-1:0]  misp_cnt_q;

    // Stops at all ones
    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] v);
        return (&v) ? v : v + 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    // No wait states, access phase completes at once
    assign access = psel_i && penable_i;
    assign wr_en  = access && pwrite_i;

    assign hit_ctrl  = (paddr_i == ADDR_CTRL);
    assign hit_epc   = (paddr_i == ADDR_EPC);
    assign hit_stall = (paddr_i == ADDR_STALL_CNT);
    assign hit_misp  = (paddr_i == ADDR_MISPRED_CNT);
    assign addr_hit  = hit_ctrl || hit_epc || hit_stall || hit_misp;

    assign pready_o  = 1'b1;
    assign pslverr_o = access && !addr_hit;

    // Read mux, zero for unmapped
    always_comb begin
        prdata_o = '0;
        if (hit_ctrl) begin
            prdata_o[CTRL_W-1:0] = ctrl_q;
        end else if (hit_epc) begin
            prdata_o[PC_W-1:0] = saved_epc_i;
        end else if (hit_stall) begin
            prdata_o[CNT_W-1:0] = stall_cnt_q;
        end else if (hit_misp) begin
            prdata_o[CNT_W-1:0] = misp_cnt_q;
        end
    end

    ////////////////////////////////////////////////////////////
    // Registers and event counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            ctrl_q      <= '0;
            stall_cnt_q <= '0;
            misp_cnt_q  <= '0;
        end else begin
            if (wr_en && hit_ctrl) begin
                ctrl_q <= pwdata_i[CTRL_W-1:0];
            end
            // Write clears, beats a same-cycle event
            if (wr_en && hit_stall) begin
                stall_cnt_q <= '0;
            end else if (stall_i) begin
                stall_cnt_q <= sat_inc(stall_cnt_q);
            end
            if (wr_en && hit_misp) begin
                misp_cnt_q <= '0;
            end else if (prewrong_i) begin
                misp_cnt_q <= sat_inc(misp_cnt_q);
            end
        end
    end

    assign int_en_o  = ctrl_q[CTRL_INT_EN_BIT];
    assign pred_en_o = ctrl_q[CTRL_PRED_EN_BIT];

endmodule

`default_nettype wire

/* rtl/intercept_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module intercept_ctrl import hazard_pkg::*; (
    input  wire             CLK,
    input  wire             rst_i,
    input  wire             int_en_i,
    input  wire             interception_i,
    input  wire  [PC_W-1:0] epc_i,
    output logic            intercepted_o,
    output logic [PC_W-1:0] saved_epc_o
);

    int_state_e state_q;
    int_state_e state_d;
    logic       take;

    // Enabled request seen while idle
    assign take = (state_q == INT_IDLE) && int_en_i && interception_i;

    ////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            INT_IDLE: begin
                if (take) begin
                    state_d = INT_TAKE;
                end
            end
            // One cycle pulse, then wait if request still up
            INT_TAKE: begin
                state_d = interception_i ? INT_HOLD : INT_IDLE;
            end
            INT_HOLD: begin
                if (!interception_i) begin
                    state_d = INT_IDLE;
                end
            end
            default: state_d = INT_IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            state_q     <= INT_IDLE;
            saved_epc_o <= '0;
        end else begin
            state_q <= state_d;
            // EPC captured at the sampling edge
            if (take) begin
                saved_epc_o <= epc_i;
            end
        end
    end

    assign intercepted_o = (state_q == INT_TAKE);

endmodule

`default_nettype wire

/* rtl/branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor import hazard_pkg::*; #(
    parameter int IDX_W = 4
) (
    input  wire            CLK,
    input  wire            rst_i,
    input  wire            pred_en_i,
    input  wire [PC_W-1:0] branch_pc_i,
    input  wire            branch_done_i,
    input  wire            ifbranch_i,
    output logic           prediction_o
);

    localparam int DEPTH = 1 << IDX_W;

    // 2-bit saturating counters
    logic [1:0]       cnt_q [DEPTH];
    logic [IDX_W-1:0] idx;
    logic [1:0]       cnt_rd;

    // Bit 0 skipped, PCs are halfword aligned
    assign idx    = branch_pc_i[IDX_W:1];
    assign cnt_rd = cnt_q[idx];

    // Taken when counter in upper half
    assign prediction_o = pred_en_i && cnt_rd[1];

    ////////////////////////////////////////////////////////////
    // Counter update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            // Weakly not taken
            for (int i = 0; i < DEPTH; i++) begin
                cnt_q[i] <= 2'b01;
            end
        end else if (branch_done_i) begin
            // Trains even with prediction off
            if (ifbranch_i) begin
                if (cnt_rd != 2'b11) begin
                    cnt_q[idx] <= cnt_rd + 2'd1;
                end
            end else begin
                if (cnt_rd != 2'b00) begin
                    cnt_q[idx] <= cnt_rd - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import hazard_pkg::*; (
    // EX stage load
    input  wire                memtoreg_i,
    input  wire                memread_i,
    input  wire [REG_ID_W-1:0] regdst_i,
    // ID stage sources
    input  wire [REG_ID_W-1:0] regsrc1_i,
    input  wire [REG_ID_W-1:0] regsrc2_i,
    input  wire [REG_ID_W-1:0] regsrc_sw_i,
    // MEM stage load
    input  wire                memtoreg_mem_i,
    input  wire                memread_mem_i,
    input  wire [REG_ID_W-1:0] regdst_mem_i,
    // ID stage jump and branch
    input  wire [REG_ID_W-1:0] regsrc1_id_i,
    input  wire                isjump_i,
    input  wire                isbranch_i,
    input  wire                ifbranch_i,
    input  wire                prediction_i,
    // Other stall and flush sources
    input  wire                ram2_conflict_i,
    input  wire                intercepted_i,
    output logic               stall_o,
    output logic               prewrong_o,
    output logic               precorrc_o,
    output logic               jr_o,
    output logic               branch_done_o,
    output logic               flush_if_o,
    output logic               flush_id_o,
    output logic               flush_ex_o
);

    logic conflict_lw;
    logic conflict_jrb;
    logic stall;
    logic prewrong;
    logic precorrc;

    ////////////////////////////////////////////////////////////
    // Hazard detection
    ////////////////////////////////////////////////////////////

    // EX load feeding any ID source
    assign conflict_lw = memtoreg_i && memread_i &&
                         ((regsrc1_i == regdst_i) ||
                          (regsrc2_i == regdst_i) ||
                          (regsrc_sw_i == regdst_i));

    // Jump or branch register still in flight from a MEM load
    assign conflict_jrb = (isbranch_i || isjump_i) &&
                          memtoreg_mem_i && memread_mem_i &&
                          (regsrc1_id_i == regdst_mem_i);

    assign stall = conflict_lw || conflict_jrb || ram2_conflict_i;

    ////////////////////////////////////////////////////////////
    // Prediction judgement
    ////////////////////////////////////////////////////////////

    // Wrong on mismatch, or taken guess on a non-branch
    assign prewrong = (isbranch_i && (prediction_i != ifbranch_i)) ||
                      (!isbranch_i && prediction_i);
    assign precorrc = isbranch_i && (prediction_i == ifbranch_i);

    // Judgement and resolve held off while frozen
    assign prewrong_o    = prewrong && !stall;
    assign precorrc_o    = precorrc && !stall;
    assign branch_done_o = isbranch_i && !stall;

    // Stall and flush outputs
    assign stall_o    = stall;
    // PC is frozen during a stall, so jr needs no mask
    assign jr_o       = isjump_i;
    assign flush_if_o = prewrong || isjump_i;
    assign flush_id_o = intercepted_i || stall;
    assign flush_ex_o = intercepted_i;

endmodule

`default_nettype wire

/* rtl/hazard_pkg.sv */
`default_nettype none

package hazard_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////

    // Register id as seen in ID, EX and MEM
    localparam int REG_ID_W = 4;
    // PC and saved EPC
    localparam int PC_W = 16;
    // Stall and mispredict event counters
    localparam int CNT_W = 16;

    // APB address and data buses
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////

    // CTRL bit positions
    localparam int CTRL_INT_EN_BIT  = 0;
    localparam int CTRL_PRED_EN_BIT = 1;
    localparam int CTRL_W           = 2;

    // Word addresses on APB
    typedef enum logic [3:0] {
        ADDR_CTRL        = 4'h0,
        ADDR_EPC         = 4'h4,
        ADDR_STALL_CNT   = 4'h8,
        ADDR_MISPRED_CNT = 4'hC
    } reg_addr_e;

    // Interception FSM
    typedef enum logic [1:0] {
        INT_IDLE = 2'd0,
        INT_TAKE = 2'd1,
        INT_HOLD = 2'd2
    } int_state_e;

endpackage

`default_nettype wire
